/* hdl/config_reg_pkg.sv */
package config_reg_pkg;

    //////////////////////////////////////////////////
    // Bus and register bank defaults
    //////////////////////////////////////////////////

    // AXI4-Lite data bus width
    parameter int data_width_default = 32;
    // Byte address width, 2 KB window
    parameter int addr_width_default = 11;
    // Registers in the bank
    parameter int register_n_default = 2;

    // Word index of the byte-writable control register
    parameter int reg_ctrl_idx   = 0;
    // Word index of the read-only doubled register
    parameter int reg_double_idx = 1;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // BRESP / RRESP codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    typedef enum logic [1:0] {w_collect, w_strobe, w_resp} wr_state_t;
    typedef enum logic [1:0] {r_idle, r_fetch, r_resp} rd_state_t;

endpackage

/* hdl/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if #(
    parameter int DATA_WIDTH = config_reg_pkg::data_width_default,
    parameter int REGISTER_N = config_reg_pkg::register_n_default
);

    // Write data toward the register bank
    logic [DATA_WIDTH-1:0]   wr_data;
    // Byte enables, one per lane
    logic [DATA_WIDTH/8-1:0] wr_strb;
    // One-hot register select, single-cycle pulse
    logic [REGISTER_N-1:0]   wr_sel;
    // Current value of every register
    logic [DATA_WIDTH-1:0]   rd_data [REGISTER_N];

    // Write engine side
    modport write_host (output wr_data, output wr_strb, output wr_sel);

    // Read engine side
    modport read_host (input rd_data);

    // Register bank side
    modport regs (input wr_data, input wr_strb, input wr_sel, output rd_data);

endinterface

/* hdl/axi_lite_write_channel.sv */
`timescale 1ns/1ps

module axi_lite_write_channel #(
    parameter int DATA_WIDTH = config_reg_pkg::data_width_default,
    parameter int ADDR_WIDTH = config_reg_pkg::addr_width_default,
    parameter int REGISTER_N = config_reg_pkg::register_n_default
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [ADDR_WIDTH-1:0]     awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [DATA_WIDTH-1:0]     wdata,
    input  logic [DATA_WIDTH/8-1:0]   wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output config_reg_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready,
    reg_bus_if.write_host             bus
);
    import config_reg_pkg::*;

    // Byte offset bits below the word index
    localparam int OFFS_W = $clog2(DATA_WIDTH / 8);
    localparam int IDX_W  = ADDR_WIDTH - OFFS_W;
    // Highest valid word index
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(REGISTER_N - 1);

    wr_state_t               state;
    logic                    aw_done;
    logic                    w_done;
    logic [IDX_W-1:0]        aw_idx;
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic [DATA_WIDTH/8-1:0] wstrb_q;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    aw_have;
    logic                    w_have;
    logic                    idx_ok;

    // Handshakes this cycle
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    // Address or data held or arriving now
    assign aw_have = aw_done || aw_hs;
    assign w_have  = w_done || w_hs;
    assign idx_ok  = (aw_idx <= IDX_LAST);

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= w_collect;
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            case (state)
                w_collect: begin
                    // Each ready drops once its half of the write is captured
                    awready <= !aw_have;
                    wready  <= !w_have;
                    aw_done <= aw_have;
                    w_done  <= w_have;
                    if (aw_have && w_have) begin
                        state <= w_strobe;
                    end
                end
                w_strobe: begin
                    bvalid <= 1'b1;
                    state  <= w_resp;
                end
                w_resp: begin
                    // Hold response until the master takes it
                    if (bready) begin
                        bvalid  <= 1'b0;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= w_collect;
                    end
                end
                default: state <= w_collect;
            endcase
        end
    end

    // Captured address index, data, strobes and response
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            aw_idx <= awaddr[ADDR_WIDTH-1:OFFS_W];
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (state == w_strobe) begin
            bresp <= idx_ok ? resp_okay : resp_slverr;
        end
    end

    //////////////////////////////////////////////////
    // Register bus drive
    //////////////////////////////////////////////////
    assign bus.wr_data = wdata_q;
    assign bus.wr_strb = wstrb_q;

    // One-hot select only in w_strobe, no bit for out-of-range index
    always_comb begin
        for (int i = 0; i < REGISTER_N; i++) begin
            bus.wr_sel[i] = (state == w_strobe) && (aw_idx == IDX_W'(i));
        end
    end

endmodule

/* hdl/axi_lite_read_channel.sv */
`timescale 1ns/1ps

module axi_lite_read_channel #(
    parameter int DATA_WIDTH = config_reg_pkg::data_width_default,
    parameter int ADDR_WIDTH = config_reg_pkg::addr_width_default,
    parameter int REGISTER_N = config_reg_pkg::register_n_default
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [ADDR_WIDTH-1:0]     araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [DATA_WIDTH-1:0]     rdata,
    output config_reg_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    reg_bus_if.read_host              bus
);
    import config_reg_pkg::*;

    localparam int OFFS_W = $clog2(DATA_WIDTH / 8);
    localparam int IDX_W  = ADDR_WIDTH - OFFS_W;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(REGISTER_N - 1);

    rd_state_t             state;
    logic [IDX_W-1:0]      ar_idx;
    logic [DATA_WIDTH-1:0] fetch_word;
    logic                  ar_hs;
    logic                  idx_ok;

    assign ar_hs  = arvalid && arready;
    assign idx_ok = (ar_idx <= IDX_LAST);

    // Word mux, zero when no register matches
    always_comb begin
        fetch_word = '0;
        for (int i = 0; i < REGISTER_N; i++) begin
            if (ar_idx == IDX_W'(i)) begin
                fetch_word = bus.rd_data[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= r_idle;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            case (state)
                r_idle: begin
                    arready <= !ar_hs;
                    if (ar_hs) begin
                        state <= r_fetch;
                    end
                end
                r_fetch: begin
                    rvalid <= 1'b1;
                    state  <= r_resp;
                end
                r_resp: begin
                    // Back-pressure just stretches this state
                    if (rready) begin
                        rvalid  <= 1'b0;
                        arready <= 1'b1;
                        state   <= r_idle;
                    end
                end
                default: state <= r_idle;
            endcase
        end
    end

    // Address index and read payload
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) begin
            ar_idx <= araddr[ADDR_WIDTH-1:OFFS_W];
        end
        if (state == r_fetch) begin
            rdata <= fetch_word;
            rresp <= idx_ok ? resp_okay : resp_slverr;
        end
    end

endmodule

/* hdl/config_reg_out.sv */
`timescale 1ns/1ps

module config_reg_out #(
    parameter int DATA_WIDTH = config_reg_pkg::data_width_default,
    parameter int REGISTER_N = config_reg_pkg::register_n_default
) (
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    reg_bus_if.regs    bus,
    output logic [7:0] output_leds
);
    import config_reg_pkg::*;

    // Control register, the only writable word
    logic [DATA_WIDTH-1:0] ctrl_q;

    // Byte-lane write while this register is selected
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl_q <= '0;
        end else if (bus.wr_sel[reg_ctrl_idx]) begin
            for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                if (bus.wr_strb[b]) begin
                    ctrl_q[b*8 +: 8] <= bus.wr_data[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////
    always_comb begin
        // Unused slots read zero
        for (int i = 0; i < REGISTER_N; i++) begin
            bus.rd_data[i] = '0;
        end
        bus.rd_data[reg_ctrl_idx] = ctrl_q;
        // Doubled copy, select bit ignored so writes do nothing
        bus.rd_data[reg_double_idx] = {ctrl_q[DATA_WIDTH-2:0], 1'b0};
    end

    // Board LEDs follow byte 0
    assign output_leds = ctrl_q[7:0];

endmodule

/* hdl/config_reg_top.sv */
`timescale 1ns/1ps

module config_reg_top #(
    parameter int DATA_WIDTH = config_reg_pkg::data_width_default,
    parameter int ADDR_WIDTH = config_reg_pkg::addr_width_default,
    parameter int REGISTER_N = config_reg_pkg::register_n_default
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,

    // Write address channel
    input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
    // Protection bits, accepted and ignored
    input  logic [2:0]              s_axi_awprot,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,

    // Write data channel
    input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,

    // Write response channel
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,

    // Read address channel
    input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic [2:0]              s_axi_arprot,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,

    // Read data channel
    output logic [DATA_WIDTH-1:0]   s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,

    // Board LEDs
    output logic [7:0]              output_leds
);

    //////////////////////////////////////////////////
    // Register bus between slave and bank
    //////////////////////////////////////////////////
    reg_bus_if #(
        .DATA_WIDTH(DATA_WIDTH),
        .REGISTER_N(REGISTER_N)
    ) reg_bus ();

    // AW/W/B engine
    axi_lite_write_channel #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .REGISTER_N(REGISTER_N)
    ) u_write_channel (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .awaddr       (s_axi_awaddr),
        .awvalid      (s_axi_awvalid),
        .awready      (s_axi_awready),
        .wdata        (s_axi_wdata),
        .wstrb        (s_axi_wstrb),
        .wvalid       (s_axi_wvalid),
        .wready       (s_axi_wready),
        .bresp        (s_axi_bresp),
        .bvalid       (s_axi_bvalid),
        .bready       (s_axi_bready),
        .bus          (reg_bus.write_host)
    );

    // AR/R engine
    axi_lite_read_channel #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .REGISTER_N(REGISTER_N)
    ) u_read_channel (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .araddr       (s_axi_araddr),
        .arvalid      (s_axi_arvalid),
        .arready      (s_axi_arready),
        .rdata        (s_axi_rdata),
        .rresp        (s_axi_rresp),
        .rvalid       (s_axi_rvalid),
        .rready       (s_axi_rready),
        .bus          (reg_bus.read_host)
    );

    // Register bank and LED drive
    config_reg_out #(
        .DATA_WIDTH(DATA_WIDTH),
        .REGISTER_N(REGISTER_N)
    ) u_reg_out (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .bus          (reg_bus.regs),
        .output_leds  (output_leds)
    );

endmodule

/* sim/tb_config_reg_top.sv */
`timescale 1ns/1ps

module tb_config_reg_top;

    // Planned transactions and worst-case cycles for one of them
    localparam int TXN_COUNT       = 50;
    localparam int CYCLES_PER_TXN  = 16;
    localparam int WATCHDOG_CYCLES = 50 * (TXN_COUNT * CYCLES_PER_TXN + 5);
    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic [10:0] s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [10:0] s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic [7:0]  output_leds;

    integer      seed;
    // Expected control register
    logic [31:0] model_ctrl;
    int          n_writes;
    int          n_reads;
    int          b_resp_count;
    int          r_resp_count;
    // Valid levels from the previous edge
    logic        b_seen;
    logic        r_seen;
    // Response channel values from the previous edge
    logic        b_hold;
    logic        r_hold;
    logic [1:0]  held_bresp;
    logic [31:0] held_rdata;
    logic [1:0]  held_rresp;

    config_reg_top UUT (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .s_axi_awaddr (s_axi_awaddr),
        .s_axi_awprot (s_axi_awprot),
        .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready),
        .s_axi_wdata  (s_axi_wdata),
        .s_axi_wstrb  (s_axi_wstrb),
        .s_axi_wvalid (s_axi_wvalid),
        .s_axi_wready (s_axi_wready),
        .s_axi_bresp  (s_axi_bresp),
        .s_axi_bvalid (s_axi_bvalid),
        .s_axi_bready (s_axi_bready),
        .s_axi_araddr (s_axi_araddr),
        .s_axi_arprot (s_axi_arprot),
        .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready),
        .s_axi_rdata  (s_axi_rdata),
        .s_axi_rresp  (s_axi_rresp),
        .s_axi_rvalid (s_axi_rvalid),
        .s_axi_rready (s_axi_rready),
        .output_leds  (output_leds)
    );

    // 4 ns clock
    always #2 S_AXI_ACLK = ~S_AXI_ACLK;

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////
    task automatic abort_run;
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Byte-lane merge of the reference model
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // AXI4-Lite master
    //////////////////////////////////////////////////
    // Order 0 sends both halves together; 1 sends address first and 2 data first
    task automatic issue_write(input logic [10:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input int order,
                               output logic [1:0] resp);
        logic        aw_sent;
        logic        w_sent;
        logic        aw_ok;
        logic        w_ok;
        logic        b_ok;
        logic [31:0] rnd;
        int          bp;
        int          waited;
        rnd     = $random(seed);
        bp      = {29'd0, rnd[2:0]};
        aw_sent = 1'b0;
        w_sent  = 1'b0;
        aw_ok   = 1'b0;
        w_ok    = 1'b0;
        b_ok    = 1'b0;
        waited  = 0;
        @(posedge S_AXI_ACLK);
        if (order != 2) begin
            s_axi_awaddr  <= addr;
            s_axi_awvalid <= 1'b1;
            aw_sent = 1'b1;
        end
        if (order != 1) begin
            s_axi_wdata  <= data;
            s_axi_wstrb  <= strb;
            s_axi_wvalid <= 1'b1;
            w_sent = 1'b1;
        end
        while (!(aw_ok && w_ok)) begin
            @(posedge S_AXI_ACLK);
            if (s_axi_awvalid && s_axi_awready) begin
                aw_ok = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_ok = 1'b1;
                s_axi_wvalid <= 1'b0;
            end
            // Second half goes out once the first one is taken
            if (!aw_sent && w_ok) begin
                s_axi_awaddr  <= addr;
                s_axi_awvalid <= 1'b1;
                aw_sent = 1'b1;
            end
            if (!w_sent && aw_ok) begin
                s_axi_wdata  <= data;
                s_axi_wstrb  <= strb;
                s_axi_wvalid <= 1'b1;
                w_sent = 1'b1;
            end
        end
        // BREADY held low for a random stretch
        while (!b_ok) begin
            @(posedge S_AXI_ACLK);
            if (s_axi_bvalid && s_axi_bready) begin
                resp = s_axi_bresp;
                b_ok = 1'b1;
                s_axi_bready <= 1'b0;
            end else if (s_axi_bvalid) begin
                if (waited >= bp) begin
                    s_axi_bready <= 1'b1;
                end
                waited++;
            end
        end
        n_writes++;
    endtask

    task automatic issue_read(input logic [10:0] addr, output logic [31:0] data,
                              output logic [1:0] resp);
        logic        ar_ok;
        logic        r_ok;
        logic [31:0] rnd;
        int          bp;
        int          waited;
        rnd    = $random(seed);
        bp     = {29'd0, rnd[2:0]};
        ar_ok  = 1'b0;
        r_ok   = 1'b0;
        waited = 0;
        @(posedge S_AXI_ACLK);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        while (!ar_ok) begin
            @(posedge S_AXI_ACLK);
            if (s_axi_arvalid && s_axi_arready) begin
                ar_ok = 1'b1;
                s_axi_arvalid <= 1'b0;
            end
        end
        while (!r_ok) begin
            @(posedge S_AXI_ACLK);
            if (s_axi_rvalid && s_axi_rready) begin
                data = s_axi_rdata;
                resp = s_axi_rresp;
                r_ok = 1'b1;
                s_axi_rready <= 1'b0;
            end else if (s_axi_rvalid) begin
                if (waited >= bp) begin
                    s_axi_rready <= 1'b1;
                end
                waited++;
            end
        end
        n_reads++;
    endtask

    // Both readbacks and the LEDs against the model
    task automatic verify_bank;
        logic [31:0] rd;
        logic [1:0]  rs;
        issue_read(11'h000, rd, rs);
        check_value("s_axi_rdata (index 0)", model_ctrl, rd);
        check_value("s_axi_rresp (index 0)", 32'(RESP_OKAY), 32'(rs));
        issue_read(11'h004, rd, rs);
        check_value("s_axi_rdata (index 1)", model_ctrl << 1, rd);
        check_value("s_axi_rresp (index 1)", 32'(RESP_OKAY), 32'(rs));
        check_value("output_leds", 32'(model_ctrl[7:0]), 32'(output_leds));
    endtask

    // Only index 0 is writable and indices 2 and up answer SLVERR
    task automatic write_and_verify(input logic [10:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb, input int order);
        logic [1:0] resp;
        logic [1:0] exp_resp;
        exp_resp = (addr[10:2] < 9'd2) ? RESP_OKAY : RESP_SLVERR;
        issue_write(addr, data, strb, order, resp);
        check_value("s_axi_bresp", 32'(exp_resp), 32'(resp));
        if (addr[10:2] == 9'd0) begin
            model_ctrl = merge_bytes(model_ctrl, data, strb);
        end
        verify_bank();
    endtask

    //////////////////////////////////////////////////
    // Protocol monitors
    //////////////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        // Payload frozen while the master stalls
        if (b_hold) begin
            check_value("s_axi_bresp (stall)", 32'(held_bresp), 32'(s_axi_bresp));
        end
        if (r_hold) begin
            check_value("s_axi_rdata (stall)", held_rdata, s_axi_rdata);
            check_value("s_axi_rresp (stall)", 32'(held_rresp), 32'(s_axi_rresp));
        end
        if (S_AXI_ARESETN && s_axi_bvalid) begin
            check_value("s_axi_awready", 32'd0, 32'(s_axi_awready));
            check_value("s_axi_wready", 32'd0, 32'(s_axi_wready));
        end
        // Every rising valid is one response
        if (S_AXI_ARESETN && s_axi_bvalid && !b_seen) begin
            b_resp_count++;
        end
        if (S_AXI_ARESETN && s_axi_rvalid && !r_seen) begin
            r_resp_count++;
        end
        b_seen     <= S_AXI_ARESETN && s_axi_bvalid;
        r_seen     <= S_AXI_ARESETN && s_axi_rvalid;
        b_hold     <= S_AXI_ARESETN && s_axi_bvalid && !s_axi_bready;
        r_hold     <= S_AXI_ARESETN && s_axi_rvalid && !s_axi_rready;
        held_bresp <= s_axi_bresp;
        held_rdata <= s_axi_rdata;
        held_rresp <= s_axi_rresp;
    end

    // Valid stays up until its handshake
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
    else begin
        $display("[ERROR] %0t ns: s_axi_bvalid expected 1 actual %b", $time, s_axi_bvalid);
        abort_run();
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (s_axi_rvalid && !s_axi_rready) |=> s_axi_rvalid)
    else begin
        $display("[ERROR] %0t ns: s_axi_rvalid expected 1 actual %b", $time, s_axi_rvalid);
        abort_run();
    end

    // Outputs idle during reset
    assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
        (!s_axi_bvalid && !s_axi_rvalid && !s_axi_awready && !s_axi_wready
         && !s_axi_arready && output_leds == 8'h00))
    else begin
        $write("[ERROR] %0t ns: reset outputs expected 0 actual bvalid %b rvalid %b ",
               $time, s_axi_bvalid, s_axi_rvalid);
        $display("awready %b wready %b arready %b leds %h",
                 s_axi_awready, s_axi_wready, s_axi_arready, output_leds);
        abort_run();
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
        $display("Watchdog timeout: transactions not finished after %0d cycles",
                 WATCHDOG_CYCLES);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] data;
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [1:0]  rs;
        seed          = 83857;
        model_ctrl    = '0;
        n_writes      = 0;
        n_reads       = 0;
        b_resp_count  = 0;
        r_resp_count  = 0;
        S_AXI_ACLK    = 1'b0;
        S_AXI_ARESETN <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awprot  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arprot  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge S_AXI_ACLK);

        // Quiet bank after reset
        check_value("s_axi_bvalid", 32'd0, 32'(s_axi_bvalid));
        check_value("s_axi_rvalid", 32'd0, 32'(s_axi_rvalid));
        check_value("output_leds", 32'd0, 32'(output_leds));
        verify_bank();

        // Full-word writes
        for (int i = 0; i < 4; i++) begin
            data = $random(seed);
            write_and_verify(11'h000, data, 4'hF, i % 3);
        end
        // Partial strobes
        for (int i = 0; i < 6; i++) begin
            data = $random(seed);
            rnd  = $random(seed);
            write_and_verify(11'h000, data, rnd[3:0], i % 3);
        end
        // Read-only register ignores writes
        data = $random(seed);
        write_and_verify(11'h004, data, 4'hF, 0);

        // Out-of-range write and read
        data = $random(seed);
        write_and_verify(11'h7FC, data, 4'hF, 1);
        issue_read(11'h010, rd, rs);
        check_value("s_axi_rdata (out of range)", 32'd0, rd);
        check_value("s_axi_rresp (out of range)", 32'(RESP_SLVERR), 32'(rs));
        verify_bank();

        // Each channel order under back-pressure
        for (int order = 0; order < 3; order++) begin
            data = $random(seed);
            rnd  = $random(seed);
            write_and_verify(11'h000, data, rnd[3:0], order);
        end

        // One response per transaction, no late extra one
        repeat (4) @(posedge S_AXI_ACLK);
        check_value("write responses", 32'(n_writes), 32'(b_resp_count));
        check_value("read responses", 32'(n_reads), 32'(r_resp_count));
        $display("Test OK");
        $finish;
    end

endmodule

/* config_reg_top.f */
hdl/config_reg_pkg.sv
hdl/reg_bus_if.sv
hdl/axi_lite_write_channel.sv
hdl/axi_lite_read_channel.sv
hdl/config_reg_out.sv
hdl/config_reg_top.sv
sim/tb_config_reg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the config_reg_top testbench with Verilator.
# Exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_config_reg_top \
    -f config_reg_top.f \
    -o tb_config_reg_top && \
./obj_dir/tb_config_reg_top || { echo "simulation failed"; exit 1; }
